// ==== rtl/hwpe_sub_pkg.sv ====
/*
  Shared widths, control register offsets and controller states of the subsystem.
  Offsets are compared on the low address byte only.
*/
`default_nettype none

package hwpe_sub_pkg;

  localparam int unsigned NR_LANES   = 4;
  localparam int unsigned WORD_BYTES = 8;

  typedef logic [31:0]        addr_t;
  typedef logic [63:0]        data_t;
  typedef logic [7:0]         strb_t;
  typedef logic signed [15:0] lane_t;
  typedef logic signed [15:0] scale_t;
  typedef logic [3:0]         shift_t;
  typedef logic [15:0]        count_t;
  // Wraps on overflow
  typedef logic signed [31:0] sum_t;

  // Job controller states
  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    COMPUTE,
    WR_REQ,
    FINISH
  } ctrl_state_e;

  localparam logic [7:0] REG_TRIGGER = 8'h00;
  localparam logic [7:0] REG_STATUS  = 8'h04;
  localparam logic [7:0] REG_SRC     = 8'h08;
  localparam logic [7:0] REG_DST     = 8'h0C;
  localparam logic [7:0] REG_LEN     = 8'h10;
  localparam logic [7:0] REG_SCALE   = 8'h14;
  localparam logic [7:0] REG_SHIFT   = 8'h18;
  localparam logic [7:0] REG_SUM     = 8'h1C;
  // Served by the top level on the free-running clock
  localparam logic [7:0] REG_CLK_EN  = 8'h9C;

endpackage

`default_nettype wire

// ==== rtl/accel_regfile.sv ====
/*
  Registers live in the low 32 bits of the data word; only be[3:0] apply.
  Configuration writes are dropped while a job runs.
*/
`timescale 1ns/1ns
`default_nettype none

module accel_regfile
  import hwpe_sub_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   reg_req_i,
  input  wire addr_t  reg_addr_i,
  input  wire logic   reg_we_i,
  input  wire strb_t  reg_be_i,
  input  wire data_t  reg_wdata_i,
  input  wire logic   busy_i,
  input  wire sum_t   sum_i,
  output logic        reg_gnt_o,
  output logic        reg_rvalid_o,
  output data_t       reg_rdata_o,
  output logic        start_o,
  output addr_t       src_o,
  output addr_t       dst_o,
  output count_t      len_o,
  output scale_t      scale_o,
  output shift_t      shift_o
);

  logic [7:0] offs;
  logic       cfg_we;
  data_t      rd_val;

  function automatic logic [31:0] be_merge(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  assign offs      = reg_addr_i[7:0];
  assign reg_gnt_o = reg_req_i;
  assign cfg_we    = reg_req_i & reg_we_i & ~busy_i;
  assign start_o   = cfg_we & (offs == REG_TRIGGER);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_o   <= '0;
      dst_o   <= '0;
      len_o   <= '0;
      scale_o <= '0;
      shift_o <= '0;
    end else if (cfg_we) begin
      case (offs)
        REG_SRC:   src_o   <= be_merge(src_o, reg_wdata_i[31:0], reg_be_i[3:0]);
        REG_DST:   dst_o   <= be_merge(dst_o, reg_wdata_i[31:0], reg_be_i[3:0]);
        REG_LEN:   len_o   <= 16'(be_merge({16'b0, len_o}, reg_wdata_i[31:0], reg_be_i[3:0]));
        REG_SCALE: scale_o <= 16'(be_merge({16'b0, scale_o}, reg_wdata_i[31:0], reg_be_i[3:0]));
        REG_SHIFT: shift_o <= 4'(be_merge({28'b0, shift_o}, reg_wdata_i[31:0], reg_be_i[3:0]));
        default: ;
      endcase
    end
  end

  always_comb begin
    case (offs)
      REG_STATUS: rd_val = {63'b0, busy_i};
      REG_SRC:    rd_val = {32'b0, src_o};
      REG_DST:    rd_val = {32'b0, dst_o};
      REG_LEN:    rd_val = {48'b0, len_o};
      REG_SCALE:  rd_val = {48'b0, scale_o};
      REG_SHIFT:  rd_val = {60'b0, shift_o};
      REG_SUM:    rd_val = {32'b0, sum_i};
      default:    rd_val = '0;
    endcase
  end

  // One response per granted access, zero data for writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rvalid_o <= 1'b0;
      reg_rdata_o  <= '0;
    end else begin
      reg_rvalid_o <= reg_req_i;
      reg_rdata_o  <= (reg_req_i && !reg_we_i) ? rd_val : '0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/accel_ctrl.sv ====
/*
  One word at a time: read, compute, write. A trigger is accepted in IDLE or FINISH.
*/
`timescale 1ns/1ns
`default_nettype none

module accel_ctrl
  import hwpe_sub_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   start_i,
  input  wire count_t len_i,
  input  wire logic   rd_done_i,
  input  wire logic   wr_done_i,
  output logic        rd_start_o,
  output logic        wr_start_o,
  output count_t      idx_o,
  output logic        compute_en_o,
  output logic        sum_clr_o,
  output logic        busy_o,
  output logic        done_o
);

  ctrl_state_e state_q, state_d;
  count_t      idx_q, idx_d;
  count_t      idx_next;
  logic        idle;
  logic        wr_start_q;

  assign idle     = (state_q == IDLE) || (state_q == FINISH);
  assign idx_next = idx_q + count_t'(1);

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    case (state_q)
      IDLE, FINISH: begin
        if (start_i) begin
          idx_d   = '0;
          state_d = (len_i == '0) ? FINISH : RD_REQ;
        end else begin
          state_d = IDLE;
        end
      end
      RD_REQ:  state_d = RD_WAIT;
      RD_WAIT: if (rd_done_i) state_d = COMPUTE;
      COMPUTE: state_d = WR_REQ;
      WR_REQ: begin
        if (wr_done_i) begin
          if (idx_next == len_i) begin
            state_d = FINISH;
          end else begin
            idx_d   = idx_next;
            state_d = RD_REQ;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      idx_q      <= '0;
      wr_start_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      idx_q      <= idx_d;
      // Result word is registered by the end of COMPUTE
      wr_start_q <= (state_q == COMPUTE);
    end
  end

  assign rd_start_o   = (state_q == RD_REQ);
  assign wr_start_o   = wr_start_q;
  assign compute_en_o = (state_q == COMPUTE);
  assign sum_clr_o    = start_i & idle;
  assign idx_o        = idx_q;
  assign busy_o       = ~idle;
  assign done_o       = (state_q == FINISH);

endmodule

`default_nettype wire

// ==== rtl/tcdm_streamer.sv ====
/*
  Single outstanding transfer; read data must come at least one cycle after grant.
  All byte lanes are always enabled.
*/
`timescale 1ns/1ns
`default_nettype none

module tcdm_streamer
  import hwpe_sub_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   rd_start_i,
  input  wire logic   wr_start_i,
  input  wire count_t idx_i,
  input  wire addr_t  src_i,
  input  wire addr_t  dst_i,
  input  wire data_t  wdata_i,
  input  wire logic   tcdm_gnt_i,
  input  wire logic   tcdm_rvalid_i,
  input  wire data_t  tcdm_rdata_i,
  output logic        tcdm_req_o,
  output addr_t       tcdm_addr_o,
  output logic        tcdm_we_o,
  output strb_t       tcdm_be_o,
  output data_t       tcdm_wdata_o,
  output logic        rd_done_o,
  output data_t       rd_data_o,
  output logic        wr_done_o
);

  addr_t offset;
  addr_t addr_q;
  data_t wdata_q;
  data_t rdata_q;
  logic  req_q;
  logic  we_q;
  logic  rd_pend_q;

  assign offset = addr_t'(idx_i) * addr_t'(WORD_BYTES);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q     <= 1'b0;
      we_q      <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      if (rd_start_i) begin
        req_q <= 1'b1;
        we_q  <= 1'b0;
      end else if (wr_start_i) begin
        req_q <= 1'b1;
        we_q  <= 1'b1;
      end else if (req_q && tcdm_gnt_i) begin
        req_q <= 1'b0;
      end
      // A granted read waits for its response
      if (req_q && tcdm_gnt_i && !we_q) begin
        rd_pend_q <= 1'b1;
      end else if (rd_done_o) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

  // Held stable from the start strobe until the grant
  always_ff @(posedge clk_i) begin
    if (rd_start_i) begin
      addr_q <= src_i + offset;
    end else if (wr_start_i) begin
      addr_q  <= dst_i + offset;
      wdata_q <= wdata_i;
    end
    if (rd_done_o) rdata_q <= tcdm_rdata_i;
  end

  assign tcdm_req_o   = req_q;
  assign tcdm_addr_o  = addr_q;
  assign tcdm_we_o    = we_q;
  assign tcdm_be_o    = '1;
  assign tcdm_wdata_o = wdata_q;

  assign rd_done_o = rd_pend_q & tcdm_rvalid_i;
  assign rd_data_o = rdata_q;
  assign wr_done_o = req_q & we_q & tcdm_gnt_i;

endmodule

`default_nettype wire

// ==== rtl/scale_engine.sv ====
/*
  Per lane: signed product, arithmetic right shift, saturate to 16 bits.
  The lane sum wraps at 32 bits.
*/
`timescale 1ns/1ns
`default_nettype none

module scale_engine
  import hwpe_sub_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   compute_en_i,
  input  wire logic   sum_clr_i,
  input  wire data_t  din_i,
  input  wire scale_t scale_i,
  input  wire shift_t shift_i,
  output data_t       dout_o,
  output sum_t        sum_o
);

  logic signed [31:0] prod    [NR_LANES];
  logic signed [31:0] shifted [NR_LANES];
  lane_t              sat     [NR_LANES];
  data_t              result;
  sum_t               word_sum;

  always_comb begin
    word_sum = '0;
    for (int i = 0; i < NR_LANES; i++) begin
      prod[i]    = $signed(din_i[16*i +: 16]) * scale_i;
      shifted[i] = prod[i] >>> shift_i;
      if (shifted[i] > 32'sd32767) begin
        sat[i] = 16'sh7FFF;
      end else if (shifted[i] < -32'sd32768) begin
        sat[i] = 16'sh8000;
      end else begin
        sat[i] = shifted[i][15:0];
      end
      result[16*i +: 16] = sat[i];
      word_sum = word_sum + sum_t'(sat[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_o <= '0;
    end else if (sum_clr_i) begin
      sum_o <= '0;
    end else if (compute_en_i) begin
      sum_o <= sum_o + word_sum;
    end
  end

  always_ff @(posedge clk_i) begin
    if (compute_en_i) dout_o <= result;
  end

endmodule

`default_nettype wire

// ==== rtl/hwpe_subsystem.sv ====
/*
  Engine registers need clk_en set first; only 0x9C is served with the clock off.
  Issue a 0x9C access only once the previous register response has arrived.
*/
`timescale 1ns/1ns
`default_nettype none

module hwpe_subsystem
  import hwpe_sub_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,

  input  wire logic  ctrl_req_i,
  input  wire addr_t ctrl_addr_i,
  input  wire logic  ctrl_we_i,
  input  wire strb_t ctrl_be_i,
  input  wire data_t ctrl_wdata_i,
  output logic       ctrl_gnt_o,
  output logic       ctrl_rvalid_o,
  output data_t      ctrl_rdata_o,

  output logic       tcdm_req_o,
  output addr_t      tcdm_addr_o,
  output logic       tcdm_we_o,
  output strb_t      tcdm_be_o,
  output data_t      tcdm_wdata_o,
  input  wire logic  tcdm_gnt_i,
  input  wire logic  tcdm_rvalid_i,
  input  wire data_t tcdm_rdata_i,

  output logic       busy_o,
  output logic       done_o
);

  logic   clk_en;
  logic   clk_en_lat;
  logic   hwpe_clk;
  logic   local_hit;

  logic   reg_req;
  logic   reg_gnt;
  logic   reg_rvalid;
  data_t  reg_rdata;

  logic   start;
  addr_t  src;
  addr_t  dst;
  count_t len;
  scale_t scale;
  shift_t shift;
  sum_t   sum;

  logic   rd_start;
  logic   wr_start;
  count_t idx;
  logic   compute_en;
  logic   sum_clr;
  logic   rd_done;
  logic   wr_done;
  data_t  rd_data;
  data_t  dout;

  assign local_hit = (ctrl_addr_i[7:0] == REG_CLK_EN);
  assign reg_req   = ctrl_req_i & ~local_hit;

  // Local clock-enable accesses are granted and answered in the request cycle
  assign ctrl_gnt_o    = local_hit ? ctrl_req_i : reg_gnt;
  assign ctrl_rvalid_o = (ctrl_req_i & local_hit) | reg_rvalid;
  assign ctrl_rdata_o  = reg_rvalid ? reg_rdata : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clk_en <= 1'b0;
    end else if (ctrl_req_i && local_hit && ctrl_we_i) begin
      clk_en <= ctrl_wdata_i[0];
    end
  end

  // Glitch-free gate: enable only changes while clk_i is low
  always_latch begin
    if (!clk_i) begin
      clk_en_lat <= clk_en;
    end
  end

  assign hwpe_clk = clk_i & clk_en_lat;

  accel_regfile i_regfile (
    .clk_i        ( hwpe_clk     ),
    .rst_ni       ( rst_ni       ),
    .reg_req_i    ( reg_req      ),
    .reg_addr_i   ( ctrl_addr_i  ),
    .reg_we_i     ( ctrl_we_i    ),
    .reg_be_i     ( ctrl_be_i    ),
    .reg_wdata_i  ( ctrl_wdata_i ),
    .busy_i       ( busy_o       ),
    .sum_i        ( sum          ),
    .reg_gnt_o    ( reg_gnt      ),
    .reg_rvalid_o ( reg_rvalid   ),
    .reg_rdata_o  ( reg_rdata    ),
    .start_o      ( start        ),
    .src_o        ( src          ),
    .dst_o        ( dst          ),
    .len_o        ( len          ),
    .scale_o      ( scale        ),
    .shift_o      ( shift        )
  );

  accel_ctrl i_ctrl (
    .clk_i        ( hwpe_clk   ),
    .rst_ni       ( rst_ni     ),
    .start_i      ( start      ),
    .len_i        ( len        ),
    .rd_done_i    ( rd_done    ),
    .wr_done_i    ( wr_done    ),
    .rd_start_o   ( rd_start   ),
    .wr_start_o   ( wr_start   ),
    .idx_o        ( idx        ),
    .compute_en_o ( compute_en ),
    .sum_clr_o    ( sum_clr    ),
    .busy_o       ( busy_o     ),
    .done_o       ( done_o     )
  );

  tcdm_streamer i_streamer (
    .clk_i         ( hwpe_clk      ),
    .rst_ni        ( rst_ni        ),
    .rd_start_i    ( rd_start      ),
    .wr_start_i    ( wr_start      ),
    .idx_i         ( idx           ),
    .src_i         ( src           ),
    .dst_i         ( dst           ),
    .wdata_i       ( dout          ),
    .tcdm_gnt_i    ( tcdm_gnt_i    ),
    .tcdm_rvalid_i ( tcdm_rvalid_i ),
    .tcdm_rdata_i  ( tcdm_rdata_i  ),
    .tcdm_req_o    ( tcdm_req_o    ),
    .tcdm_addr_o   ( tcdm_addr_o   ),
    .tcdm_we_o     ( tcdm_we_o     ),
    .tcdm_be_o     ( tcdm_be_o     ),
    .tcdm_wdata_o  ( tcdm_wdata_o  ),
    .rd_done_o     ( rd_done       ),
    .rd_data_o     ( rd_data       ),
    .wr_done_o     ( wr_done       )
  );

  scale_engine i_engine (
    .clk_i        ( hwpe_clk   ),
    .rst_ni       ( rst_ni     ),
    .compute_en_i ( compute_en ),
    .sum_clr_i    ( sum_clr    ),
    .din_i        ( rd_data    ),
    .scale_i      ( scale      ),
    .shift_i      ( shift      ),
    .dout_o       ( dout       ),
    .sum_o        ( sum        )
  );

endmodule

`default_nettype wire

// ==== sim/tb_hwpe_subsystem.sv ====
/*
  TCDM model grants after 0 to 3 random cycles and answers reads one cycle after the grant.
  Writes into the TCDM model only update the bytes selected by tcdm_be_o.
  Control accesses are issued one at a time and wait for their response.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_hwpe_subsystem
  import hwpe_sub_pkg::*;
();

  localparam addr_t CTRL_BASE   = 32'h1A10_0000;
  localparam int    BUS_TIMEOUT = 20;
  localparam int    JOB_TIMEOUT = 4000;

  logic  clk;
  logic  rst_n;

  logic  ctrl_req;
  addr_t ctrl_addr;
  logic  ctrl_we;
  strb_t ctrl_be;
  data_t ctrl_wdata;
  logic  ctrl_gnt;
  logic  ctrl_rvalid;
  data_t ctrl_rdata;

  logic  tcdm_req;
  addr_t tcdm_addr;
  logic  tcdm_we;
  strb_t tcdm_be;
  data_t tcdm_wdata;
  logic  tcdm_gnt;
  logic  tcdm_rvalid;
  data_t tcdm_rdata;

  logic  busy;
  logic  done;

  data_t       mem [addr_t];
  logic [31:0] lcg_state = 32'd96271;
  sum_t        exp_sum;
  int          done_cnt = 0;
  int          req_cycles = 0;
  int          gnt_delay = 0;
  logic        gnt_armed = 1'b0;

  hwpe_subsystem DUT (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .ctrl_req_i    ( ctrl_req    ),
    .ctrl_addr_i   ( ctrl_addr   ),
    .ctrl_we_i     ( ctrl_we     ),
    .ctrl_be_i     ( ctrl_be     ),
    .ctrl_wdata_i  ( ctrl_wdata  ),
    .ctrl_gnt_o    ( ctrl_gnt    ),
    .ctrl_rvalid_o ( ctrl_rvalid ),
    .ctrl_rdata_o  ( ctrl_rdata  ),
    .tcdm_req_o    ( tcdm_req    ),
    .tcdm_addr_o   ( tcdm_addr   ),
    .tcdm_we_o     ( tcdm_we     ),
    .tcdm_be_o     ( tcdm_be     ),
    .tcdm_wdata_o  ( tcdm_wdata  ),
    .tcdm_gnt_i    ( tcdm_gnt    ),
    .tcdm_rvalid_i ( tcdm_rvalid ),
    .tcdm_rdata_i  ( tcdm_rdata  ),
    .busy_o        ( busy        ),
    .done_o        ( done        )
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic data_t mem_peek(input addr_t addr);
    return mem.exists(addr) ? mem[addr] : '0;
  endfunction

  // Merge of a written word into the stored one, byte by byte
  function automatic data_t apply_strobe(input data_t old_word, input data_t new_word,
                                         input strb_t be);
    data_t res;
    res = old_word;
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Expected output word; also adds its lanes into exp_sum
  function automatic data_t ref_scale_word(input data_t din, input scale_t scale,
                                           input shift_t shift);
    data_t  res;
    lane_t  lane;
    lane_t  lane_out;
    longint prod;
    longint q;
    res = '0;
    for (int i = 0; i < NR_LANES; i++) begin
      lane = din[16*i +: 16];
      prod = longint'(lane) * longint'(scale);
      q    = prod >>> shift;
      if (q > 32767) begin
        q = 32767;
      end else if (q < -32768) begin
        q = -32768;
      end
      lane_out = lane_t'(q);
      res[16*i +: 16] = lane_out;
      exp_sum = exp_sum + sum_t'(lane_out);
    end
    return res;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error at %0t ns: %s: got 0x%016h, expected 0x%016h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_sum(input sum_t got, input sum_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error at %0t ns: %s: got %0d, expected %0d",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error at %0t ns: %s: got %b, expected %b",
                                  $time, what, got, exp));
    end
  endtask

  // TCDM memory model
  always @(posedge clk) begin
    tcdm_rvalid <= 1'b0;
    if (tcdm_req && tcdm_gnt) begin
      tcdm_gnt  <= 1'b0;
      gnt_armed = 1'b0;
      if (tcdm_we) begin
        mem[tcdm_addr] = apply_strobe(mem_peek(tcdm_addr), tcdm_wdata, tcdm_be);
      end else begin
        tcdm_rvalid <= 1'b1;
        tcdm_rdata  <= mem_peek(tcdm_addr);
      end
    end else if (tcdm_req) begin
      if (!gnt_armed) begin
        gnt_armed = 1'b1;
        gnt_delay = int'((lcg_next() >> 16) & 32'd3);
      end
      if (gnt_delay == 0) begin
        tcdm_gnt <= 1'b1;
      end else begin
        gnt_delay--;
      end
    end
  end

  always @(posedge clk) begin
    if (done) done_cnt++;
    if (tcdm_req) req_cycles++;
  end

  // Called right after a rising edge; returns on the edge that sampled the response
  task automatic bus_access(input logic [7:0] offs, input logic we, input data_t wdata,
                            output data_t rdata);
    int   cycles;
    logic local_acc;
    cycles    = 0;
    local_acc = (offs == REG_CLK_EN);
    ctrl_req   <= 1'b1;
    ctrl_addr  <= CTRL_BASE | addr_t'(offs);
    ctrl_we    <= we;
    ctrl_be    <= '1;
    ctrl_wdata <= wdata;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > BUS_TIMEOUT) begin
        stop_with_failure($sformatf("Timeout: no control grant for offset 0x%02h", offs));
      end
    end while (!ctrl_gnt);
    ctrl_req <= 1'b0;
    if (local_acc) begin
      check_bit(ctrl_rvalid, 1'b1, "clk_en response in the grant cycle");
    end else begin
      cycles = 0;
      do begin
        @(posedge clk);
        cycles++;
        if (cycles > BUS_TIMEOUT) begin
          stop_with_failure($sformatf("Timeout: no control response for offset 0x%02h", offs));
        end
      end while (!ctrl_rvalid);
      check_bit(cycles == 1, 1'b1, "register response one cycle after grant");
    end
    rdata = ctrl_rdata;
  endtask

  task automatic write_reg(input logic [7:0] offs, input data_t wdata);
    data_t rdata;
    bus_access(offs, 1'b1, wdata, rdata);
    check_data(rdata, '0, "write response data");
  endtask

  task automatic read_reg(input logic [7:0] offs, output data_t rdata);
    bus_access(offs, 1'b0, '0, rdata);
  endtask

  task automatic program_reg(input logic [7:0] offs, input data_t value);
    data_t rdata;
    write_reg(offs, value);
    read_reg(offs, rdata);
    check_data(rdata, value, $sformatf("read-back of offset 0x%02h", offs));
  endtask

  task automatic run_job(input addr_t src, input addr_t dst, input count_t len,
                         input scale_t scale, input shift_t shift);
    data_t rdata;
    data_t exp_word;
    int    done0;
    int    req0;
    int    cycles;
    for (int i = 0; i < int'(len); i++) begin
      mem[src + addr_t'(i * WORD_BYTES)] = {lcg_next(), lcg_next()};
    end
    program_reg(REG_SRC, {32'b0, src});
    program_reg(REG_DST, {32'b0, dst});
    program_reg(REG_LEN, {48'b0, len});
    program_reg(REG_SCALE, {48'b0, scale});
    program_reg(REG_SHIFT, {60'b0, shift});
    done0 = done_cnt;
    req0  = req_cycles;
    write_reg(REG_TRIGGER, 64'd1);
    if (len != '0) begin
      check_bit(busy, 1'b1, "busy_o after trigger");
    end
    cycles = 0;
    while (done_cnt == done0) begin
      @(posedge clk);
      cycles++;
      if (cycles > JOB_TIMEOUT) begin
        stop_with_failure("Timeout: done_o did not pulse at the end of the job");
      end
    end
    // Let any extra done pulse show up
    repeat (4) @(posedge clk);
    check_bit(done_cnt == done0 + 1, 1'b1, "exactly one done_o pulse");
    read_reg(REG_STATUS, rdata);
    check_bit(rdata[0], 1'b0, "status busy bit after done");
    exp_sum = '0;
    for (int i = 0; i < int'(len); i++) begin
      exp_word = ref_scale_word(mem_peek(src + addr_t'(i * WORD_BYTES)), scale, shift);
      check_data(mem_peek(dst + addr_t'(i * WORD_BYTES)), exp_word,
                 $sformatf("destination word %0d", i));
    end
    read_reg(REG_SUM, rdata);
    check_sum(sum_t'(rdata[31:0]), exp_sum, "lane sum");
    if (len == '0) begin
      check_bit(req_cycles == req0, 1'b1, "no TCDM request for zero-length job");
    end
  endtask

  initial begin
    data_t rdata;
    clk         = 1'b0;
    rst_n       = 1'b0;
    ctrl_req    = 1'b0;
    ctrl_addr   = '0;
    ctrl_we     = 1'b0;
    ctrl_be     = '0;
    ctrl_wdata  = '0;
    tcdm_gnt    = 1'b0;
    tcdm_rvalid = 1'b0;
    tcdm_rdata  = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    check_bit(busy, 1'b0, "busy_o after reset");
    check_bit(done, 1'b0, "done_o after reset");
    check_bit(tcdm_req, 1'b0, "tcdm_req_o after reset");
    check_bit(ctrl_rvalid, 1'b0, "ctrl_rvalid_o after reset");

    // Clock enable is served locally
    read_reg(REG_CLK_EN, rdata);
    check_data(rdata, '0, "clk_en read data");
    write_reg(REG_CLK_EN, 64'd1);
    read_reg(REG_CLK_EN, rdata);
    check_data(rdata, '0, "clk_en read data after enable");

    read_reg(REG_STATUS, rdata);
    check_data(rdata, '0, "status when idle");
    read_reg(8'h20, rdata);
    check_data(rdata, '0, "unmapped offset 0x20");
    read_reg(8'h44, rdata);
    check_data(rdata, '0, "unmapped offset 0x44");

    run_job(32'h0000_1000, 32'h0000_3000, 16'd8, scale_t'(lcg_next()), shift_t'(lcg_next()));
    // Large scale forces saturation
    run_job(32'h0000_1100, 32'h0000_3100, 16'd5, 16'sh7FFF, 4'd1);
    run_job(32'h0000_1200, 32'h0000_3200, 16'd0, 16'sd3, 4'd0);
    run_job(32'h0000_1000, 32'h0000_3400, 16'd12, scale_t'(lcg_next()), shift_t'(lcg_next()));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hwpe_sub.f ====
rtl/hwpe_sub_pkg.sv
rtl/accel_regfile.sv
rtl/accel_ctrl.sv
rtl/tcdm_streamer.sv
rtl/scale_engine.sv
rtl/hwpe_subsystem.sv
sim/tb_hwpe_subsystem.sv
